// File: include/gat_tb_model.svh
`ifndef GAT_TB_MODEL_SVH
`define GAT_TB_MODEL_SVH

function automatic int unsigned lcg_next(input int unsigned state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

function automatic int rand_upto(input int n);
  lcg_state = lcg_next(lcg_state);
  return int'((lcg_state >> 16) % n);
endfunction

function automatic int to_int(input logic [FEAT_W-1:0] v);
  return int'($signed(v));
endfunction

// Leaky score, shift to exponent, clamp, power of two
function automatic int node_weight(input att_vec_t att, input feat_vec_t target,
                                   input feat_vec_t feat);
  int score;
  int leaky;
  int expo;
  score = 0;
  for (int k = 0; k < NUM_FEAT; k++) begin
    score += to_int(att.src[k]) * to_int(target[k]) + to_int(att.nbr[k]) * to_int(feat[k]);
  end
  leaky = (score < 0) ? (score >>> LEAKY_SHIFT) : score;
  expo  = leaky >>> SCORE_SHIFT;
  if (expo < 0) expo = 0;
  if (expo > WEIGHT_EXP_MAX) expo = WEIGHT_EXP_MAX;
  return 1 << expo;
endfunction

// First node is the target and is scored against itself too
function automatic result_t model_result(input att_vec_t att, input node_t nodes[$]);
  result_t r;
  int      w;
  r = '0;
  foreach (nodes[i]) begin
    w = node_weight(att, nodes[0].feat, nodes[i].feat);
    for (int k = 0; k < NUM_FEAT; k++) begin
      r.feat_sum[k] = r.feat_sum[k] + ACC_W'(w * to_int(nodes[i].feat[k]));
    end
    r.weight_sum = r.weight_sum + WSUM_W'(w);
  end
  return r;
endfunction

task automatic fill_att(input int base, input int span);
  for (int k = 0; k < NUM_FEAT; k++) begin
    att_vec_i.src[k] = FEAT_W'(base + rand_upto(span));
    att_vec_i.nbr[k] = FEAT_W'(base + rand_upto(span));
  end
endtask

task automatic start_test();
  err_start_q = errors;
  res_start_q = results_seen;
endtask

task automatic finish_test(input string name);
  if (errors == err_start_q) begin
    $display("test %s: ok, %0d results", name, results_seen - res_start_q);
  end else begin
    $display("test %s: %0d errors", name, errors - err_start_q);
  end
endtask

`endif

// File: dv/gat_layer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gat_layer_tb;

  import gat_pkg::*;

  localparam int NODE_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 4000;

  logic        clk;
  logic        rst_n;
  logic        node_valid_i;
  logic        node_ready_o;
  node_t       node_i;
  att_vec_t    att_vec_i;
  logic        result_valid_o;
  logic        result_ready_i;
  result_t     result_o;

  result_t     exp_q[$];
  result_t     exp_head;
  result_t     held_data_q;
  logic        held_q;
  logic        saw_stall;
  int          errors;
  int          results_seen;
  int          err_start_q;
  int          res_start_q;
  int          ready_mode;
  int unsigned lcg_state;
  int unsigned ready_state;

  `include "gat_tb_model.svh"

  gat_layer #(
    .NODE_FIFO_DEPTH (4),
    .COEF_FIFO_DEPTH (8)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .node_valid_i   (node_valid_i),
    .node_ready_o   (node_ready_o),
    .node_i         (node_i),
    .att_vec_i      (att_vec_i),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Mode 0 always ready, 1 random runs, 2 held low
  initial begin
    int   run_left;
    logic low;
    result_ready_i = 1'b0;
    ready_state    = 1707;
    run_left       = 0;
    low            = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      if (ready_mode == 1) begin
        if (run_left == 0) begin
          ready_state = lcg_next(ready_state);
          low         = ready_state[24];
          run_left    = 1 + int'((ready_state >> 8) % 24);
        end
        run_left--;
        result_ready_i = !low;
      end else begin
        result_ready_i = (ready_mode == 0);
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      held_q <= 1'b0;
      assert (!result_valid_o) else begin
        errors++;
        $display("FAIL t=%0t result_valid_o high during reset", $time);
      end
    end else begin
      if (node_valid_i && !node_ready_o) saw_stall = 1'b1;
      if (held_q) begin
        assert (result_valid_o && result_o == held_data_q) else begin
          errors++;
          $display("FAIL t=%0t result dropped or changed while held", $time);
        end
      end
      held_q      <= result_valid_o && !result_ready_i;
      held_data_q <= result_o;
      if (result_valid_o && result_ready_i) begin
        results_seen++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Result arrived at %0t with no result expected", $time);
        end else begin
          exp_head = exp_q.pop_front();
          assert (result_o == exp_head) else begin
            errors++;
            $display("FAIL t=%0t result mismatch: got %h expected %h",
                     $time, result_o, exp_head);
          end
        end
      end
    end
  end

  task automatic apply_reset();
    rst_n        = 1'b0;
    node_valid_i = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  // Ready depends only on FIFO occupancy, so it is stable until the edge
  task automatic send_node(input node_t nd);
    int waited;
    waited       = 0;
    node_i       = nd;
    node_valid_i = 1'b1;
    while (!node_ready_o && waited < NODE_TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (!node_ready_o) begin
      errors++;
      $display("Timeout: node_ready_o stayed low for %0d cycles", NODE_TIMEOUT);
    end
    @(posedge clk);
    #2;
    node_valid_i = 1'b0;
  endtask

  task automatic send_subgraph(input int n, input int gap_max, input bit track,
                               input int feat_range);
    node_t nodes[$];
    node_t nd;
    for (int i = 0; i < n; i++) begin
      for (int k = 0; k < NUM_FEAT; k++) nd.feat[k] = FEAT_W'(rand_upto(feat_range));
      nd.first = (i == 0);
      nd.last  = (i == n - 1);
      nodes.push_back(nd);
    end
    if (track) exp_q.push_back(model_result(att_vec_i, nodes));
    foreach (nodes[i]) begin
      send_node(nodes[i]);
      repeat (rand_upto(gap_max + 1)) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout: %0d expected results never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  initial begin
    node_t   nd;
    result_t hand;
    errors       = 0;
    results_seen = 0;
    lcg_state    = 1707;
    ready_mode   = 0;
    saw_stall    = 1'b0;
    node_i       = '0;
    att_vec_i    = '0;
    apply_reset();

    start_test();
    fill_att(10, 1);
    nd.feat  = {NUM_FEAT{FEAT_W'(20)}};
    nd.first = 1'b1;
    nd.last  = 1'b1;
    // Self score 8 * 10 * 20 = 1600 gives exponent 6
    hand.feat_sum   = {NUM_FEAT{ACC_W'(64 * 20)}};
    hand.weight_sum = WSUM_W'(64);
    exp_q.push_back(hand);
    send_node(nd);
    wait_drain();
    finish_test("single node");

    start_test();
    repeat (3) begin
      fill_att(-8, 16);
      repeat (4) send_subgraph(1 + rand_upto(MAX_NODES), 0, 1'b1, 256);
      wait_drain();
    end
    finish_test("random subgraphs");

    start_test();
    fill_att(-8, 1);
    send_subgraph(6, 0, 1'b1, 128);
    wait_drain();
    fill_att(127, 1);
    send_subgraph(6, 0, 1'b1, 128);
    wait_drain();
    finish_test("score clamps");

    start_test();
    fill_att(-8, 16);
    saw_stall  = 1'b0;
    ready_mode = 1;
    repeat (6) send_subgraph(8 + rand_upto(9), 0, 1'b1, 256);
    ready_mode = 0;
    wait_drain();
    assert (saw_stall) else begin
      errors++;
      $display("node_ready_o never dropped under result back-pressure");
    end
    finish_test("result back-pressure");

    start_test();
    repeat (6) send_subgraph(1 + rand_upto(MAX_NODES), 3, 1'b1, 256);
    wait_drain();
    finish_test("input gaps");

    // Leave a held result and a partial subgraph in flight, then reset
    start_test();
    ready_mode = 2;
    send_subgraph(3, 0, 1'b0, 256);
    nd.last = 1'b0;
    send_node(nd);
    nd.first = 1'b0;
    send_node(nd);
    repeat (8) @(posedge clk);
    #2;
    apply_reset();
    ready_mode = 0;
    // Partial subgraph reaches the accumulators before the next reset
    send_node(nd);
    send_node(nd);
    repeat (8) @(posedge clk);
    #2;
    apply_reset();
    send_subgraph(5, 0, 1'b1, 256);
    wait_drain();
    finish_test("reset after traffic");

    $display("summary: %0d results compared, %0d errors", results_seen, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: gat_layer.f
+incdir+include
hw/gat_pkg.sv
hw/stream_fifo.sv
hw/attn_score.sv
hw/feature_aggregator.sv
hw/gat_layer.sv
dv/gat_layer_tb.sv

// File: hw/attn_score.sv
`timescale 1ns/10ps
`default_nettype none

module attn_score (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             node_valid_i,
  output logic                  node_ready_o,
  input  wire gat_pkg::node_t   node_i,
  input  wire gat_pkg::att_vec_t att_vec_i,
  output logic                  coef_valid_o,
  input  wire logic             coef_ready_i,
  output gat_pkg::coef_t        coef_o
);

  import gat_pkg::*;

  // Stage one
  logic      s1_valid_q;
  feat_vec_t s1_feat_q;
  logic      s1_last_q;
  feat_vec_t target_q;
  logic      s1_ready;

  // Stage two
  logic  s2_valid_q;
  coef_t s2_coef_q;
  logic  s2_ready;

  logic signed [SCORE_W-1:0] score;
  logic signed [SCORE_W-1:0] leaky;
  logic signed [SCORE_W-1:0] exp_raw;
  logic [EXP_W-1:0]          exp_clamped;
  logic [WEIGHT_W-1:0]       weight;

  // A stage takes a new item when empty or when its item moves on
  assign s2_ready     = !s2_valid_q || coef_ready_i;
  assign s1_ready     = !s1_valid_q || s2_ready;
  assign node_ready_o = s1_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= node_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // Target register changes only when the item ahead of it has left stage one
  always_ff @(posedge clk) begin
    if (node_valid_i && s1_ready) begin
      s1_feat_q <= node_i.feat;
      s1_last_q <= node_i.last;
      if (node_i.first) begin
        target_q <= node_i.feat;
      end
    end
  end

  always_comb begin
    score = '0;
    for (int k = 0; k < NUM_FEAT; k++) begin
      score = score + $signed(att_vec_i.src[k]) * $signed(target_q[k])
                    + $signed(att_vec_i.nbr[k]) * $signed(s1_feat_q[k]);
    end

    // Leaky slope of 1/8 on the negative side
    if (score < 0) begin
      leaky = score >>> LEAKY_SHIFT;
    end else begin
      leaky = score;
    end

    exp_raw = leaky >>> SCORE_SHIFT;
    if (exp_raw < 0) begin
      exp_clamped = '0;
    end else if (exp_raw > WEIGHT_EXP_MAX) begin
      exp_clamped = EXP_W'(WEIGHT_EXP_MAX);
    end else begin
      exp_clamped = exp_raw[EXP_W-1:0];
    end

    // Power of two stands in for the exponential
    weight = WEIGHT_W'(1) << exp_clamped;
  end

  always_ff @(posedge clk) begin
    if (s1_valid_q && s2_ready) begin
      s2_coef_q.feat   <= s1_feat_q;
      s2_coef_q.weight <= weight;
      s2_coef_q.last   <= s1_last_q;
    end
  end

  assign coef_valid_o = s2_valid_q;
  assign coef_o       = s2_coef_q;

endmodule

`default_nettype wire

// File: hw/feature_aggregator.sv
`timescale 1ns/10ps
`default_nettype none

module feature_aggregator (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            coef_valid_i,
  output logic                 coef_ready_o,
  input  wire gat_pkg::coef_t  coef_i,
  output logic                 result_valid_o,
  input  wire logic            result_ready_i,
  output gat_pkg::result_t     result_o
);

  import gat_pkg::*;

  acc_vec_t          acc_q;
  logic [WSUM_W-1:0] wsum_q;
  acc_vec_t          acc_next;
  logic [WSUM_W-1:0] wsum_next;
  logic              result_valid_q;
  result_t           result_q;
  logic              accept;

  // Stall the coefficient stream while a result waits
  assign coef_ready_o = !result_valid_q;
  assign accept       = coef_valid_i && coef_ready_o;

  always_comb begin
    acc_t term;
    for (int k = 0; k < NUM_FEAT; k++) begin
      // Weight is unsigned, so widen with a zero before the signed multiply
      term        = $signed({1'b0, coef_i.weight}) * $signed(coef_i.feat[k]);
      acc_next[k] = acc_q[k] + term;
    end
    wsum_next = wsum_q + WSUM_W'(coef_i.weight);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q          <= '0;
      wsum_q         <= '0;
      result_valid_q <= 1'b0;
    end else begin
      if (result_valid_q && result_ready_i) begin
        result_valid_q <= 1'b0;
      end
      if (accept) begin
        if (coef_i.last) begin
          // Subgraph done, start the next one from zero
          acc_q          <= '0;
          wsum_q         <= '0;
          result_valid_q <= 1'b1;
        end else begin
          acc_q  <= acc_next;
          wsum_q <= wsum_next;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && coef_i.last) begin
      result_q.feat_sum   <= acc_next;
      result_q.weight_sum <= wsum_next;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_o       = result_q;

endmodule

`default_nettype wire

// File: hw/gat_layer.sv
`timescale 1ns/10ps
`default_nettype none

module gat_layer #(
  parameter int NODE_FIFO_DEPTH = 4,
  parameter int COEF_FIFO_DEPTH = 8
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              node_valid_i,
  output logic                   node_ready_o,
  input  wire gat_pkg::node_t    node_i,
  input  wire gat_pkg::att_vec_t att_vec_i,
  output logic                   result_valid_o,
  input  wire logic              result_ready_i,
  output gat_pkg::result_t       result_o
);

  import gat_pkg::*;

  // Node FIFO to scorer
  logic  node_q_valid;
  logic  node_q_ready;
  node_t node_q;

  // Scorer to coefficient FIFO
  logic  coef_valid;
  logic  coef_ready;
  coef_t coef;

  // Coefficient FIFO to aggregator
  logic  coef_q_valid;
  logic  coef_q_ready;
  coef_t coef_q;

  stream_fifo #(
    .payload_t  (node_t),
    .FIFO_DEPTH (NODE_FIFO_DEPTH)
  ) i_node_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (node_valid_i),
    .in_ready_o  (node_ready_o),
    .in_data_i   (node_i),
    .out_valid_o (node_q_valid),
    .out_ready_i (node_q_ready),
    .out_data_o  (node_q)
  );

  attn_score i_attn_score (
    .clk          (clk),
    .rst_n        (rst_n),
    .node_valid_i (node_q_valid),
    .node_ready_o (node_q_ready),
    .node_i       (node_q),
    .att_vec_i    (att_vec_i),
    .coef_valid_o (coef_valid),
    .coef_ready_i (coef_ready),
    .coef_o       (coef)
  );

  stream_fifo #(
    .payload_t  (coef_t),
    .FIFO_DEPTH (COEF_FIFO_DEPTH)
  ) i_coef_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (coef_valid),
    .in_ready_o  (coef_ready),
    .in_data_i   (coef),
    .out_valid_o (coef_q_valid),
    .out_ready_i (coef_q_ready),
    .out_data_o  (coef_q)
  );

  feature_aggregator i_aggregator (
    .clk            (clk),
    .rst_n          (rst_n),
    .coef_valid_i   (coef_q_valid),
    .coef_ready_o   (coef_q_ready),
    .coef_i         (coef_q),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

endmodule

`default_nettype wire

// File: hw/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // Layer dimensions
  localparam int NUM_FEAT  = 4;
  localparam int MAX_NODES = 16;

  // Datapath widths
  localparam int FEAT_W   = 8;
  localparam int SCORE_W  = 19;
  localparam int WEIGHT_W = 16;
  localparam int ACC_W    = 32;
  localparam int WSUM_W   = 24;

  // Score to weight mapping
  localparam int WEIGHT_EXP_MAX = 15;
  localparam int SCORE_SHIFT    = 8;
  localparam int LEAKY_SHIFT    = 3;
  localparam int EXP_W          = $clog2(WEIGHT_EXP_MAX + 1);

  typedef logic signed [FEAT_W-1:0] feat_t;
  typedef feat_t [NUM_FEAT-1:0] feat_vec_t;

  typedef logic signed [ACC_W-1:0] acc_t;
  typedef acc_t [NUM_FEAT-1:0] acc_vec_t;

  // src applies to the target node, nbr to every node of the subgraph
  typedef struct packed {
    feat_vec_t src;
    feat_vec_t nbr;
  } att_vec_t;

  // First item of a subgraph is the target node
  typedef struct packed {
    feat_vec_t feat;
    logic      first;
    logic      last;
  } node_t;

  typedef struct packed {
    feat_vec_t           feat;
    logic [WEIGHT_W-1:0] weight;
    logic                last;
  } coef_t;

  // Host divides feat_sum by weight_sum
  typedef struct packed {
    acc_vec_t          feat_sum;
    logic [WSUM_W-1:0] weight_sum;
  } result_t;

endpackage

`default_nettype wire

// File: hw/stream_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_data_i,
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_data_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count_q != CNT_W'(FIFO_DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap explicitly so any depth works
        if (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=gat_layer_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module "$TOP" --Mdir "$OBJ_DIR" -f gat_layer.f

"./$OBJ_DIR/V$TOP" | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation passed"
